// ==== design/stopwatch_pkg.sv ====
package stopwatch_pkg;

	////////////////////////////////////////////////////////////
	// Sizes and timing
	////////////////////////////////////////////////////////////

	localparam int NUM_DIGITS = 4;          // Decimal digits on the display

	// 100 MHz clock assumed
	localparam int TICK_DIV = 1_000_000;    // One count step per 10 ms
	localparam int SCAN_DIV = 50_000;       // 0.5 ms per digit on the display

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// Control states of the run/hold/stop machine
	typedef enum logic [1:0] {
		STAT_RESUME = 2'd0,                 // Counting
		STAT_PAUSE  = 2'd1,                 // Holding
		STAT_STOP   = 2'd2                  // Stopped, time kept
	} sw_state_t;

	typedef logic [3:0] bcd_t;              // One decimal digit, 0 to 9

	// Whole time value, most significant digit first
	typedef struct packed {
		bcd_t d3;
		bcd_t d2;
		bcd_t d1;
		bcd_t d0;                           // Fastest digit
	} time_t;

	// Active-low segments, a at bit 6 down to g at bit 0
	typedef logic [6:0] seg_t;

	// One-clock press strobes from the button front end
	typedef struct packed {
		logic pause_press;
		logic stop_press;
	} btn_evt_t;

endpackage

// ==== design/button_pulse.sv ====
`timescale 1ns/1ps

module button_pulse (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    pause_btn_n,   // Raw level, low while pressed
	input  logic                    stop_btn_n,    // Raw level, low while pressed
	output stopwatch_pkg::btn_evt_t btn_evt
);
	import stopwatch_pkg::*;

	// Bit 1 is pause and bit 0 is stop, same order as btn_evt_t
	logic [1:0] raw_n;
	logic [1:0] sync1_n;        // First synchronizer stage
	logic [1:0] sync2_n;        // Second stage, safe to use
	logic [1:0] prev_n;         // Level one clock earlier
	logic [1:0] fall;           // High to low on the synced level

	assign raw_n = {pause_btn_n, stop_btn_n};

	// Press seen as falling edge of the active-low level
	assign fall = prev_n & ~sync2_n;

	////////////////////////////////////////////////////////////
	// Sync and edge stages
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync1_n <= 2'b11;   // Released level
			sync2_n <= 2'b11;
			prev_n  <= 2'b11;   // No false edge after reset
			btn_evt <= '0;
		end
		else
		begin
			sync1_n <= raw_n;
			sync2_n <= sync1_n;
			prev_n  <= sync2_n;
			btn_evt <= fall;    // Registered pulse, one clock per press
		end
	end

endmodule

// ==== design/stopwatch_ctrl.sv ====
`timescale 1ns/1ps

module stopwatch_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  stopwatch_pkg::btn_evt_t btn_evt,
	output logic                    run,      // High while counting
	output logic                    clear     // One-clock time clear
);
	import stopwatch_pkg::*;

	sw_state_t state;
	sw_state_t next_state;
	logic      next_clear;

	////////////////////////////////////////////////////////////
	// Next state decision
	////////////////////////////////////////////////////////////

	// Pause press is checked first in every state
	always_comb
	begin
		next_state = state;             // Hold by default
		next_clear = 1'b0;
		case (state)
			STAT_RESUME:
			begin
				if (btn_evt.pause_press)
					next_state = STAT_PAUSE;
				else if (btn_evt.stop_press)
					next_state = STAT_STOP;
			end
			STAT_PAUSE:
			begin
				if (btn_evt.pause_press)
					next_state = STAT_RESUME;   // Back to counting
				else if (btn_evt.stop_press)
					next_state = STAT_STOP;
			end
			STAT_STOP:
			begin
				if (btn_evt.pause_press)
					next_state = STAT_RESUME;   // Carry on from held time
				else if (btn_evt.stop_press)
				begin
					// Second stop restarts from zero
					next_state = STAT_RESUME;
					next_clear = 1'b1;
				end
			end
			default:
			begin
				next_state = STAT_RESUME;       // Unused code 2'd3
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// State and output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= STAT_RESUME;   // Counts right out of reset
			run   <= 1'b1;
			clear <= 1'b0;
		end
		else
		begin
			state <= next_state;
			run   <= (next_state == STAT_RESUME);   // Tracks the new state
			clear <= next_clear;
		end
	end

endmodule

// ==== design/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen #(
	parameter int tick_div = stopwatch_pkg::TICK_DIV   // Clocks per tick
) (
	input  logic clk,
	input  logic rst_n,
	input  logic run,       // Count enable level
	input  logic clear,     // Restart the period
	output logic tick       // One-clock count step
);
	import stopwatch_pkg::*;

	logic [$clog2(tick_div)-1:0] div_cnt;   // Position inside the period

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end
		else if (clear)
		begin
			div_cnt <= '0;          // Full period before the first step
			tick    <= 1'b0;
		end
		else if (run)
		begin
			if (div_cnt == tick_div - 1)
			begin
				div_cnt <= '0;      // Wrap
				tick    <= 1'b1;
			end
			else
			begin
				div_cnt <= div_cnt + 1'b1;
				tick    <= 1'b0;
			end
		end
		else
			tick <= 1'b0;           // Hold count while stopped or paused
	end

endmodule

// ==== design/bcd_digit.sv ====
`timescale 1ns/1ps

module bcd_digit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                enable,   // Step this digit
	input  logic                clear,    // Synchronous zero
	output stopwatch_pkg::bcd_t value,
	output logic                carry     // High while at 9
);
	import stopwatch_pkg::*;

	// Carry feeds the next digit's enable, so it is a level on the value
	assign carry = (value == 4'd9);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			value <= 4'd0;
		else if (clear)
			value <= 4'd0;          // Clear beats a coincident step
		else if (enable)
		begin
			if (carry)
				value <= 4'd0;      // 9 rolls to 0
			else
				value <= value + 4'd1;
		end
	end

endmodule

// ==== design/display_scan.sv ====
`timescale 1ns/1ps

module display_scan #(
	parameter int scan_div = stopwatch_pkg::SCAN_DIV   // Clocks per digit
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  stopwatch_pkg::time_t                   time_value,
	output stopwatch_pkg::seg_t                    seg,   // Shared segment bus
	output logic [stopwatch_pkg::NUM_DIGITS-1:0]   an     // Active-low digit selects
);
	import stopwatch_pkg::*;

	bcd_t [NUM_DIGITS-1:0]          digits;       // Index 0 is least significant
	logic [$clog2(scan_div)-1:0]    scan_cnt;     // Dwell counter
	logic [$clog2(NUM_DIGITS)-1:0]  idx;          // Digit being shown
	logic [$clog2(NUM_DIGITS)-1:0]  next_idx;
	logic                           scan_wrap;    // Dwell time over

	// Segment patterns, abcdefg, low lights the segment
	function automatic seg_t seg_code(input bcd_t d);
		case (d)
			4'd0: seg_code = 7'b0000001;
			4'd1: seg_code = 7'b1001111;
			4'd2: seg_code = 7'b0010010;
			4'd3: seg_code = 7'b0000110;
			4'd4: seg_code = 7'b1001100;
			4'd5: seg_code = 7'b0100100;
			4'd6: seg_code = 7'b0100000;
			4'd7: seg_code = 7'b0001111;
			4'd8: seg_code = 7'b0000000;
			4'd9: seg_code = 7'b0000100;
			default: seg_code = 7'b1111111;   // Blank on bad code
		endcase
	endfunction

	assign digits = time_value;

	////////////////////////////////////////////////////////////
	// Scan rotation
	////////////////////////////////////////////////////////////

	always_comb
	begin
		scan_wrap = (scan_cnt == scan_div - 1);
		next_idx  = idx;
		if (scan_wrap)
			next_idx = (idx == NUM_DIGITS - 1) ? '0 : idx + 1'b1;   // Rotate
	end

	// Select and pattern come from the same index in the same register stage
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			scan_cnt <= '0;
			idx      <= '0;
			an       <= {{(NUM_DIGITS-1){1'b1}}, 1'b0};   // Digit 0 on
			seg      <= seg_code(4'd0);                   // Digits clear at reset
		end
		else
		begin
			scan_cnt <= scan_wrap ? '0 : scan_cnt + 1'b1;
			idx      <= next_idx;
			an       <= ~(NUM_DIGITS'(1) << next_idx);
			seg      <= seg_code(digits[next_idx]);       // Refreshed every clock
		end
	end

endmodule

// ==== design/stopwatch_top.sv ====
`timescale 1ns/1ps

module stopwatch_top #(
	parameter int tick_div = stopwatch_pkg::TICK_DIV    // Smaller in simulation
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 pause_btn_n,
	input  logic                                 stop_btn_n,
	output stopwatch_pkg::time_t                 time_value,
	output logic                                 running,
	output stopwatch_pkg::seg_t                  seg,
	output logic [stopwatch_pkg::NUM_DIGITS-1:0] an
);
	import stopwatch_pkg::*;

	btn_evt_t               btn_evt;
	logic                   clear;
	logic                   tick;
	logic [NUM_DIGITS-1:0]  digit_en;       // Ripple enable per digit
	logic [NUM_DIGITS-1:0]  digit_carry;    // At-9 flags
	bcd_t [NUM_DIGITS-1:0]  digit_val;

	////////////////////////////////////////////////////////////
	// Buttons and control
	////////////////////////////////////////////////////////////

	button_pulse btn_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.pause_btn_n (pause_btn_n),
		.stop_btn_n  (stop_btn_n),
		.btn_evt     (btn_evt)
	);

	stopwatch_ctrl ctrl_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.btn_evt (btn_evt),
		.run     (running),     // Run level goes straight out
		.clear   (clear)
	);

	tick_gen #(.tick_div(tick_div)) tick_i (
		.clk   (clk),
		.rst_n (rst_n),
		.run   (running),
		.clear (clear),
		.tick  (tick)
	);

	////////////////////////////////////////////////////////////
	// Digit chain
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_DIGITS; i++)
	begin : g_digit
		if (i == 0)
		begin : g_lsd
			assign digit_en[i] = tick;
		end
		else
		begin : g_upper
			// Steps only when every lower digit is at 9
			assign digit_en[i] = digit_en[i-1] & digit_carry[i-1];
		end

		bcd_digit digit_i (
			.clk    (clk),
			.rst_n  (rst_n),
			.enable (digit_en[i]),
			.clear  (clear),
			.value  (digit_val[i]),
			.carry  (digit_carry[i])
		);
	end

	assign time_value = digit_val;  // Digit 0 lands in d0

	display_scan scan_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.time_value (time_value),
		.seg        (seg),
		.an         (an)
	);

endmodule

// ==== verification/stopwatch_properties.sv ====
`timescale 1ns/1ps

module stopwatch_properties (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  stopwatch_pkg::time_t                 time_value,
	input  logic                                 running,
	input  stopwatch_pkg::seg_t                  seg,
	input  logic [stopwatch_pkg::NUM_DIGITS-1:0] an,
	input  stopwatch_pkg::btn_evt_t              btn_evt,
	input  logic                                 clear,
	input  stopwatch_pkg::sw_state_t             state
);
	import stopwatch_pkg::*;

	int fail_cnt = 0;   // Read by the testbench

	// Active-low abcdefg patterns for 0..9, a at bit 6
	localparam seg_t SEG_TABLE [10] = '{7'h01, 7'h4F, 7'h12, 7'h06, 7'h4C,
		7'h24, 7'h20, 7'h0F, 7'h00, 7'h04};

	// Decimal value of the four digits
	function automatic int to_int(input time_t t);
		return t.d3 * 1000 + t.d2 * 100 + t.d1 * 10 + t.d0;
	endfunction

	// Pattern expected for the digit picked by a one-hot-low select
	function automatic seg_t expected_seg(input time_t t, input logic [NUM_DIGITS-1:0] sel);
		bcd_t d;
		d = !sel[0] ? t.d0 : !sel[1] ? t.d1 : !sel[2] ? t.d2 : t.d3;
		return (d <= 4'd9) ? SEG_TABLE[d] : 7'h7F;
	endfunction

	////////////////////////////////////////////////////////////
	// Counting, holding, clearing
	////////////////////////////////////////////////////////////

	// Only +1 modulo 10000, or zero right after a clear
	a_count_step: assert property (@(posedge clk) disable iff (!rst_n)
		(time_value != $past(time_value)) |->
			(to_int(time_value) == (to_int($past(time_value)) + 1) % 10000) ||
			(time_value == '0 && $past(clear)))
		else begin fail_cnt++; $error("time changed by other than one step"); end

	// One cycle of slack for a tick already in flight
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(!running && !$past(running)) |=> $stable(time_value))
		else begin fail_cnt++; $error("time moved while not running"); end

	a_digit_range: assert property (@(posedge clk) disable iff (!rst_n)
		time_value.d0 <= 9 && time_value.d1 <= 9 && time_value.d2 <= 9 && time_value.d3 <= 9)
		else begin fail_cnt++; $error("digit out of decimal range"); end

	a_pause_toggle: assert property (@(posedge clk) disable iff (!rst_n)
		btn_evt.pause_press |=> (running == ($past(state) != STAT_RESUME)))
		else begin fail_cnt++; $error("pause press did not toggle running"); end

	a_stop: assert property (@(posedge clk) disable iff (!rst_n)
		(btn_evt.stop_press && !btn_evt.pause_press && state != STAT_STOP) |=>
			(!running && state == STAT_STOP))
		else begin fail_cnt++; $error("stop press did not stop"); end

	// Second stop, zero and running again
	a_restart: assert property (@(posedge clk) disable iff (!rst_n)
		(btn_evt.stop_press && !btn_evt.pause_press && state == STAT_STOP) |->
			##[1:2] (time_value == '0 && running))
		else begin fail_cnt++; $error("restart from stop did not clear"); end

	////////////////////////////////////////////////////////////
	// Display scan
	////////////////////////////////////////////////////////////

	a_one_select: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~an))
		else begin fail_cnt++; $error("digit select not one-hot low"); end

	a_seg_match: assert property (@(posedge clk) disable iff (!rst_n)
		seg == expected_seg($past(time_value), an))
		else begin fail_cnt++; $error("segments disagree with selected digit"); end

endmodule

bind stopwatch_top stopwatch_properties props_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.time_value (time_value),
	.running    (running),
	.seg        (seg),
	.an         (an),
	.btn_evt    (btn_evt),
	.clear      (clear),
	.state      (ctrl_i.state)
);

// ==== verification/stopwatch_tb.sv ====
`timescale 1ns/1ps

module stopwatch_tb;
	import stopwatch_pkg::*;

	////////////////////////////////////////////////////////////
	// Upper bounds of the test lengths in clocks
	////////////////////////////////////////////////////////////

	localparam int CLK_PERIOD  = 20;
	localparam int LEN_RESET   = 8;
	localparam int LEN_COUNT   = 100;
	localparam int LEN_HOLD    = 100;
	localparam int LEN_STOP    = 150;
	localparam int LEN_CARRY   = 600;         // Past 99 at four clocks per tick
	localparam int LEN_WRAP    = 41_000;      // Up to 10000 steps
	localparam int LEN_SCAN    = 200_000;     // Four dwells of the default scan divider
	localparam int LEN_TOTAL   = LEN_RESET + LEN_COUNT + LEN_HOLD + LEN_STOP +
		LEN_CARRY + LEN_WRAP + LEN_SCAN;
	localparam int WATCHDOG_NS = (LEN_TOTAL + 1000) * CLK_PERIOD;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  pause_btn_n;
	logic                  stop_btn_n;
	time_t                 time_value;
	logic                  running;
	seg_t                  seg;
	logic [NUM_DIGITS-1:0] an;

	integer seed = 73633;
	int     tests_passed = 0;
	int     tests_failed = 0;

	stopwatch_top #(.tick_div(4)) dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.pause_btn_n (pause_btn_n),
		.stop_btn_n  (stop_btn_n),
		.time_value  (time_value),
		.running     (running),
		.seg         (seg),
		.an          (an)
	);

	always #10 clk = ~clk;   // 20 ns period

	// Random hold of 1 to 6 clocks before release
	task automatic press_button(input logic is_stop);
		int hold;
		hold = 1 + ($unsigned($random(seed)) % 6);
		@(posedge clk);
		if (is_stop)
			stop_btn_n <= 1'b0;
		else
			pause_btn_n <= 1'b0;
		repeat (hold) @(posedge clk);
		stop_btn_n  <= 1'b1;
		pause_btn_n <= 1'b1;
		repeat (6) @(posedge clk);   // Sync, edge and FSM stages
	endtask

	task automatic end_test(input string name, input int fails_before);
		int fails;
		@(negedge clk);
		fails = dut_i.props_i.fail_cnt - fails_before;
		if (fails == 0)
		begin
			tests_passed++;
			$display("PASSED %s", name);
		end
		else
		begin
			tests_failed++;
			$display("FAILED %s: expected 0 assertion failures, actual %0d", name, fails);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int    mark;
		time_t held;
		rst_n       = 1'b0;
		pause_btn_n = 1'b1;   // Released
		stop_btn_n  = 1'b1;
		repeat (LEN_RESET) @(posedge clk);
		rst_n <= 1'b1;

		mark = dut_i.props_i.fail_cnt;
		while (time_value < 16'h0010) @(posedge clk);
		end_test("counting", mark);

		mark = dut_i.props_i.fail_cnt;
		press_button(1'b0);                  // Pause
		held = time_value;
		repeat (20) @(posedge clk);
		press_button(1'b0);                  // Resume
		while (time_value == held) @(posedge clk);
		end_test("holding", mark);

		mark = dut_i.props_i.fail_cnt;
		press_button(1'b1);                  // Stop
		repeat (20) @(posedge clk);
		press_button(1'b0);                  // Resume from stop
		held = time_value;
		while (time_value == held) @(posedge clk);
		press_button(1'b1);
		press_button(1'b1);                  // Second stop clears
		while (time_value < 16'h0003) @(posedge clk);
		end_test("stop_restart", mark);

		mark = dut_i.props_i.fail_cnt;
		while (time_value < 16'h0120) @(posedge clk);
		end_test("carry", mark);

		mark = dut_i.props_i.fail_cnt;
		while (time_value != 16'h9999) @(posedge clk);
		while (time_value == 16'h9999) @(posedge clk);
		end_test("wrap", mark);

		mark = dut_i.props_i.fail_cnt;
		while (an != 4'b0111) @(posedge clk);   // Rotation reaches the top digit
		while (an == 4'b0111) @(posedge clk);   // Whole dwell of the top digit
		end_test("display_scan", mark);

		$display("Tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, dut_i.props_i.fail_cnt);
		if (tests_failed == 0 && dut_i.props_i.fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Run timed out before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== all.f ====
design/stopwatch_pkg.sv
design/button_pulse.sv
design/stopwatch_ctrl.sv
design/tick_gen.sv
design/bcd_digit.sv
design/display_scan.sv
design/stopwatch_top.sv
verification/stopwatch_properties.sv
verification/stopwatch_tb.sv
